//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = vending_machine_tb
FILELIST = vending_machine.f

BUILD    = obj_dir
SIM_BIN  = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) hdl/vend_consts.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- hdl/change_dispenser.sv
// Change dispenser that pays out one coin per cycle, largest coin first
`default_nettype none

`include "vend_consts.svh"

module change_dispenser import vend_pkg::*; (
    input  wire        clock,
    input  wire        reset,
    input  wire        load,
    input  credit_t    change_amount,
    output coin_code_t coin_to_return,
    output logic       change_done
);

    credit_t    remaining;
    logic       busy;
    credit_t    source;      // Amount still owed this cycle
    coin_code_t next_coin;

    //////////////////////////////////////////////////
    // Greedy coin choice
    //////////////////////////////////////////////////
    always_comb begin
        // First coin comes straight from the load value
        source = load ? change_amount : remaining;

        if (source >= `VEND_COIN_100) begin
            next_coin = coin_100;
        end else if (source >= `VEND_COIN_50) begin
            next_coin = coin_50;
        end else if (source >= `VEND_COIN_25) begin
            next_coin = coin_25;
        end else if (source >= `VEND_COIN_10) begin
            next_coin = coin_10;
        end else if (source >= `VEND_COIN_5) begin
            next_coin = coin_5;
        end else if (source >= `VEND_COIN_1) begin
            next_coin = coin_1;
        end else begin
            next_coin = coin_none;
        end
    end

    //////////////////////////////////////////////////
    // Payout sequencing
    //////////////////////////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            remaining      <= '0;
            busy           <= 1'b0;
            coin_to_return <= coin_none;
            change_done    <= 1'b0;
        end else if (load || busy) begin
            coin_to_return <= next_coin;
            if (next_coin == coin_none) begin
                // Nothing left, finish with a single done pulse
                busy        <= 1'b0;
                change_done <= 1'b1;
            end else begin
                remaining   <= source - coin_value(next_coin);
                busy        <= 1'b1;
                change_done <= 1'b0;
            end
        end else begin
            coin_to_return <= coin_none;
            change_done    <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/coin_accumulator.sv
// Coin accumulator that sums inserted coin values into the running credit
`default_nettype none

module coin_accumulator import vend_pkg::*; (
    input  wire        clock,
    input  wire        reset,
    input  coin_code_t coin,
    input  wire        collecting,     // Coins count only while high
    input  wire        credit_clear,   // One-cycle clear after change is paid
    output credit_t    credit
);

    //////////////////////////////////////////////////
    // Coin value lookup
    //////////////////////////////////////////////////
    credit_t coin_amount;

    always_comb begin
        coin_amount = coin_value(coin);   // Code 7 maps to 0
    end

    //////////////////////////////////////////////////
    // Credit register
    //////////////////////////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            credit <= '0;
        end else if (credit_clear) begin
            // Clear wins over any coin arriving in the same cycle
            credit <= '0;
        end else if (collecting) begin
            credit <= credit + coin_amount;
        end
    end

endmodule

`default_nettype wire

//--- hdl/selection_decoder.sv
// Keypad decoder from row and column keys to slot code and row price
`default_nettype none

`include "vend_consts.svh"

module selection_decoder import vend_pkg::*; (
    input  keypad_t    keys,
    output selection_t selection
);

    logic       row_hit;
    logic       col_hit;
    logic [1:0] row_idx;
    logic [2:0] col_idx;

    //////////////////////////////////////////////////
    // Lowest pressed row and column win
    //////////////////////////////////////////////////
    always_comb begin
        row_hit = 1'b0;
        row_idx = '0;
        // Scan from the top so the lowest set bit is left last
        for (int i = `VEND_ROWS - 1; i >= 0; i--) begin
            if (keys.row[i]) begin
                row_hit = 1'b1;
                row_idx = 2'(i);
            end
        end
    end

    always_comb begin
        col_hit = 1'b0;
        col_idx = '0;
        for (int j = `VEND_COLS - 1; j >= 0; j--) begin
            if (keys.col[j]) begin
                col_hit = 1'b1;
                col_idx = 3'(j);
            end
        end
    end

    //////////////////////////////////////////////////
    // Slot code and price
    //////////////////////////////////////////////////
    always_comb begin
        selection.valid = row_hit && col_hit;   // Need one key of each kind
        if (selection.valid) begin
            selection.slot = slot_t'(row_idx) * slot_t'(`VEND_COLS) + slot_t'(col_idx)
                             + slot_t'(1);
        end else begin
            selection.slot = '0;
        end

        case (row_idx)
            2'd0:    selection.price = `VEND_PRICE_A;
            2'd1:    selection.price = `VEND_PRICE_B;
            2'd2:    selection.price = `VEND_PRICE_C;
            default: selection.price = `VEND_PRICE_D;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/vend_consts.svh
// Vending machine constants for widths, grid size, row prices and coin values
`ifndef VEND_CONSTS_SVH
`define VEND_CONSTS_SVH

//////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////
`define VEND_CREDIT_W 10            // Credit and change, in cents
`define VEND_SLOT_W   5             // Slot code, 0 to 20
`define VEND_COIN_W   3             // Coin code

// Snack grid, 4 rows of 5
`define VEND_ROWS 4
`define VEND_COLS 5

//////////////////////////////////////////////////
// Row prices in cents
//////////////////////////////////////////////////
`define VEND_PRICE_A 10'd100
`define VEND_PRICE_B 10'd125
`define VEND_PRICE_C 10'd150
`define VEND_PRICE_D 10'd175

// Coin values in cents
`define VEND_COIN_1   10'd1
`define VEND_COIN_5   10'd5
`define VEND_COIN_10  10'd10
`define VEND_COIN_25  10'd25
`define VEND_COIN_50  10'd50
`define VEND_COIN_100 10'd100

`endif

//--- hdl/vend_controller.sv
// Sale controller that accepts a paid selection, holds it for release, then runs change
`default_nettype none

module vend_controller import vend_pkg::*; (
    input  wire        clock,
    input  wire        reset,
    input  credit_t    credit,
    input  selection_t selection,
    input  wire        food_dispensed,   // Drop sensor level
    input  wire        change_done,
    output logic       collecting,
    output logic       credit_clear,
    output logic       load,
    output credit_t    change_amount,
    output slot_t      food_selection
);

    typedef enum logic [1:0] {
        st_collecting,
        st_releasing_food,
        st_returning_change
    } state_t;

    state_t state;
    logic   accept;

    //////////////////////////////////////////////////
    // Sale decision and handshake-free control levels
    //////////////////////////////////////////////////
    always_comb begin
        // Enough credit for the selected row
        accept = (state == st_collecting) && selection.valid
                 && (credit >= selection.price);

        // Coins are refused on the accepting edge, the change is fixed there
        collecting = (state == st_collecting) && !accept;

        credit_clear = (state == st_returning_change) && change_done;
    end

    //////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state          <= st_collecting;
            food_selection <= '0;
            load           <= 1'b0;
        end else begin
            load <= 1'b0;   // Pulse by default
            case (state)
                st_collecting: begin
                    if (accept) begin
                        state          <= st_releasing_food;
                        food_selection <= selection.slot;
                    end
                end
                st_releasing_food: begin
                    // Hold the slot until the drop sensor reports
                    if (food_dispensed) begin
                        state          <= st_returning_change;
                        food_selection <= '0;
                        load           <= 1'b1;
                    end
                end
                st_returning_change: begin
                    if (change_done) begin
                        state <= st_collecting;
                    end
                end
                default: begin
                    state <= st_collecting;
                end
            endcase
        end
    end

    // Change owed, captured with the sale
    always_ff @(posedge clock) begin
        if (accept) begin
            change_amount <= credit - selection.price;
        end
    end

endmodule

`default_nettype wire

//--- hdl/vend_pkg.sv
// Vending machine types for coins, keypad, slots and credit
`default_nettype none

`include "vend_consts.svh"

package vend_pkg;

    typedef logic [`VEND_CREDIT_W-1:0] credit_t;  // Cents
    typedef logic [`VEND_SLOT_W-1:0]   slot_t;    // 0 is no slot, 1..20 is A1..D5

    // Same codes for inserted and returned coins
    typedef enum logic [`VEND_COIN_W-1:0] {
        coin_none   = 3'd0,
        coin_1      = 3'd1,
        coin_5      = 3'd2,
        coin_10     = 3'd3,
        coin_25     = 3'd4,
        coin_50     = 3'd5,
        coin_100    = 3'd6,
        coin_unused = 3'd7
    } coin_code_t;

    typedef struct packed {
        logic [`VEND_ROWS-1:0] row;   // A is bit 0
        logic [`VEND_COLS-1:0] col;   // ONE is bit 0
    } keypad_t;

    typedef struct packed {
        logic    valid;
        slot_t   slot;
        credit_t price;
    } selection_t;

    // Value of a coin code, unused code counts for nothing
    function automatic credit_t coin_value(input coin_code_t code);
        case (code)
            coin_1:   return `VEND_COIN_1;
            coin_5:   return `VEND_COIN_5;
            coin_10:  return `VEND_COIN_10;
            coin_25:  return `VEND_COIN_25;
            coin_50:  return `VEND_COIN_50;
            coin_100: return `VEND_COIN_100;
            default:  return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- hdl/vending_machine.sv
// Vending machine top level joining credit, keypad, sale control and change payout
`default_nettype none

module vending_machine import vend_pkg::*; (
    input  wire        clock,
    input  wire        reset,
    input  coin_code_t coin_inserted,
    input  keypad_t    keys,
    input  wire        food_dispensed,
    output credit_t    num_to_display,   // Binary cents
    output slot_t      food_selection,
    output coin_code_t coin_to_return
);

    selection_t selection;
    logic       collecting;
    logic       credit_clear;
    logic       load;
    credit_t    change_amount;
    logic       change_done;

    // Credit register feeds the display directly
    coin_accumulator u_coin_accumulator (
        .clock        (clock),
        .reset        (reset),
        .coin         (coin_inserted),
        .collecting   (collecting),
        .credit_clear (credit_clear),
        .credit       (num_to_display)
    );

    selection_decoder u_selection_decoder (
        .keys      (keys),
        .selection (selection)
    );

    vend_controller u_vend_controller (
        .clock          (clock),
        .reset          (reset),
        .credit         (num_to_display),
        .selection      (selection),
        .food_dispensed (food_dispensed),
        .change_done    (change_done),
        .collecting     (collecting),
        .credit_clear   (credit_clear),
        .load           (load),
        .change_amount  (change_amount),
        .food_selection (food_selection)
    );

    change_dispenser u_change_dispenser (
        .clock          (clock),
        .reset          (reset),
        .load           (load),
        .change_amount  (change_amount),
        .coin_to_return (coin_to_return),
        .change_done    (change_done)
    );

endmodule

`default_nettype wire

//--- test/vending_machine_tb.sv
// Vending machine testbench with a cycle model of credit, slot and change coins
`default_nettype none

`include "vend_consts.svh"

module vending_machine_tb import vend_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_sales       = 40;
    localparam int max_sale_cycles = 60;
    localparam int max_cycles      = num_sales * max_sale_cycles;

    localparam credit_t coin_cents [8] = '{10'd0, `VEND_COIN_1, `VEND_COIN_5, `VEND_COIN_10,
                                           `VEND_COIN_25, `VEND_COIN_50, `VEND_COIN_100, 10'd0};
    localparam credit_t row_price [4] = '{`VEND_PRICE_A, `VEND_PRICE_B, `VEND_PRICE_C,
                                          `VEND_PRICE_D};
    localparam coin_code_t greedy_order [6] = '{coin_100, coin_50, coin_25, coin_10, coin_5,
                                                coin_1};

    typedef enum {ph_collect, ph_release, ph_pay} phase_t;

    logic       clock = 1'b0;
    logic       reset;
    coin_code_t coin_inserted;
    keypad_t    keys;
    logic       food_dispensed;
    credit_t    num_to_display;
    slot_t      food_selection;
    coin_code_t coin_to_return;

    // Reference model state
    phase_t     phase;
    credit_t    exp_credit;
    slot_t      exp_slot;
    coin_code_t exp_coin;
    coin_code_t exp_coins [$];
    credit_t    change_due;
    credit_t    paid_sum;
    logic       done_due;

    integer seed;
    int     error_count = 0;
    int     cycle_count = 0;

    vending_machine uut (
        .clock          (clock),
        .reset          (reset),
        .coin_inserted  (coin_inserted),
        .keys           (keys),
        .food_dispensed (food_dispensed),
        .num_to_display (num_to_display),
        .food_selection (food_selection),
        .coin_to_return (coin_to_return)
    );

    always #10 clock = ~clock;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    function automatic void report_mismatch(input string name, input int got, input int expected);
        $display("Mismatch at %0d ns: %s got %0d expected %0d", $time, name, got, expected);
        error_count++;
    endfunction

    // Lowest pressed key index or -1 when none
    function automatic int lowest_key(input logic [4:0] bits);
        for (int i = 0; i < 5; i++) begin
            if (bits[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic void queue_change_coins(input credit_t amount);
        credit_t rem;
        rem = amount;
        exp_coins.delete();
        for (int i = 0; i < 6; i++) begin
            while (rem >= coin_cents[greedy_order[i]]) begin
                exp_coins.push_back(greedy_order[i]);
                rem = rem - coin_cents[greedy_order[i]];
            end
        end
    endfunction

    function automatic coin_code_t any_coin();
        int unsigned pick;
        pick = $unsigned($random(seed));
        return coin_code_t'(pick[2:0]);   // Includes code 7
    endfunction

    function automatic coin_code_t big_coin();
        int unsigned pick;
        pick = $unsigned($random(seed)) % 32'd5;
        return coin_code_t'(pick[2:0] + 3'd3);   // 10 to 100 or code 7
    endfunction

    //////////////////////////////////////////////////
    // Reference model stepping once per rising edge
    //////////////////////////////////////////////////
    always @(posedge clock) begin
        int r;
        int c;
        if (reset) begin
            phase      = ph_collect;
            exp_credit = '0;
            exp_slot   = '0;
            exp_coin   = coin_none;
            change_due = '0;
            done_due   = 1'b0;
            exp_coins.delete();
        end else begin
            case (phase)
                ph_collect: begin
                    r = lowest_key({1'b0, keys.row});
                    c = lowest_key(keys.col);
                    if (r >= 0 && c >= 0 && exp_credit >= row_price[r]) begin
                        exp_slot   = slot_t'(r * `VEND_COLS + c + 1);
                        change_due = exp_credit - row_price[r];
                        queue_change_coins(change_due);
                        phase      = ph_release;   // Coin on this edge is refused
                    end else begin
                        exp_credit = exp_credit + coin_cents[coin_inserted];
                    end
                end
                ph_release: begin
                    if (food_dispensed) begin
                        exp_slot = '0;
                        phase    = ph_pay;
                    end
                end
                default: begin
                    if (done_due) begin
                        exp_credit = '0;
                        done_due   = 1'b0;
                        phase      = ph_collect;
                    end else if (exp_coins.size() > 0) begin
                        exp_coin = exp_coins.pop_front();
                    end else begin
                        exp_coin = coin_none;
                        done_due = 1'b1;
                    end
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Port checks on the falling edge where outputs are settled
    //////////////////////////////////////////////////
    assert property (@(negedge clock) disable iff (reset) num_to_display == exp_credit)
        else report_mismatch("num_to_display", int'(num_to_display), int'(exp_credit));

    assert property (@(negedge clock) disable iff (reset) food_selection == exp_slot)
        else report_mismatch("food_selection", int'(food_selection), int'(exp_slot));

    assert property (@(negedge clock) disable iff (reset) coin_to_return == exp_coin)
        else report_mismatch("coin_to_return", int'(coin_to_return), int'(exp_coin));

    // Running total of returned coins
    always @(negedge clock) begin
        if (!reset) begin
            if (phase == ph_pay) begin
                paid_sum = paid_sum + coin_cents[coin_to_return];
                if (done_due) begin
                    assert (paid_sum == change_due) else begin
                        $display("At %0d ns the returned coins add up to %0d cents, not %0d",
                                 $time, paid_sum, change_due);
                        error_count++;
                    end
                end
            end else begin
                paid_sum = '0;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("Timeout after %0d cycles with %0d errors so far", cycle_count, error_count);
            $display("** FAIL **");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    task automatic run_sale();
        int unsigned hold;
        keys.row = 4'($random(seed));
        if (keys.row == '0) begin
            keys.row = 4'b1000;
        end
        keys.col = 5'($random(seed));
        if (keys.col == '0) begin
            keys.col = 5'b10000;
        end
        coin_inserted = any_coin();
        @(posedge clock);
        #2;
        // Keys stay held while credit climbs past the price
        while (food_selection == '0) begin
            coin_inserted = big_coin();
            @(posedge clock);
            #2;
        end
        hold = $unsigned($random(seed)) % 32'd5;
        repeat (hold) begin
            coin_inserted = any_coin();   // Ignored during the sale
            @(posedge clock);
            #2;
        end
        food_dispensed = 1'b1;
        coin_inserted  = any_coin();
        @(posedge clock);
        #2;
        food_dispensed = 1'b0;
        keys           = '0;
        while (num_to_display != '0) begin
            coin_inserted = any_coin();
            @(posedge clock);
            #2;
        end
        coin_inserted = coin_none;
    endtask

    initial begin
        seed           = 32'hce08102d;
        reset          = 1'b1;
        coin_inserted  = coin_none;
        keys           = '0;
        food_dispensed = 1'b0;
        repeat (4) @(posedge clock);
        #2;
        reset = 1'b0;
        repeat (2) @(posedge clock);
        #2;
        for (int s = 0; s < num_sales; s++) begin
            run_sale();
        end
        repeat (3) @(posedge clock);
        $display("Run complete: %0d sales, %0d errors", num_sales, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vending_machine.f
+incdir+hdl
hdl/vend_pkg.sv
hdl/coin_accumulator.sv
hdl/selection_decoder.sv
hdl/vend_controller.sv
hdl/change_dispenser.sv
hdl/vending_machine.sv
test/vending_machine_tb.sv
